//--- include/dcache_params.svh
`ifndef DCACHE_PARAMS_SVH
`define DCACHE_PARAMS_SVH

// ==================================================
// cache geometry
// ==================================================

// byte address width.
`define DCACHE_ADDR_W 32
// data word width.
`define DCACHE_WORD_W 32

`define DCACHE_OFFSET_BITS 4   // byte offset inside one line.
`define DCACHE_INDEX_BITS 2    // 4 sets.

// associativity and line length.
`define DCACHE_WAYS 4
`define DCACHE_LINE_WORDS 4

`endif

//--- design/dcache_pkg.sv
package dcache_pkg;

`include "dcache_params.svh"

    // ==================================================
    // data and address fields
    // ==================================================
    typedef logic [`DCACHE_WORD_W-1:0] word_t;
    typedef logic [`DCACHE_WORD_W/8-1:0] strobe_t;   // all zero means read.
    typedef logic [`DCACHE_ADDR_W-1:0] addr_t;

    typedef logic [`DCACHE_ADDR_W-`DCACHE_INDEX_BITS-`DCACHE_OFFSET_BITS-1:0] tag_t;
    typedef logic [`DCACHE_INDEX_BITS-1:0] index_t;
    typedef logic [$clog2(`DCACHE_LINE_WORDS)-1:0] word_sel_t;
    typedef logic [$clog2(`DCACHE_WAYS)-1:0] way_t;

    // ==================================================
    // per-way metadata and controller states
    // ==================================================
    typedef struct packed {
        tag_t tag;
        logic valid;
        logic dirty;
    } meta_t;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        EVICT,     // dirty victim goes out first.
        FILL,
        RESPOND
    } cache_state_t;

endpackage

//--- design/dbus_front.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dbus_front (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  dreq_valid,
    input  dcache_pkg::addr_t     dreq_addr,
    input  dcache_pkg::strobe_t   dreq_strobe,
    input  dcache_pkg::word_t     dreq_wdata,
    input  logic                  busy,
    input  logic                  done,
    input  dcache_pkg::word_t     done_rdata,
    output logic                  addr_ok,
    output logic                  data_ok,
    output dcache_pkg::word_t     rdata,
    output logic                  req_start,
    output dcache_pkg::tag_t      req_tag,
    output dcache_pkg::index_t    req_index,
    output dcache_pkg::word_sel_t req_word,
    output dcache_pkg::strobe_t   req_strobe,
    output dcache_pkg::word_t     req_wdata
);
    localparam int BYTE_BITS = $clog2(`DCACHE_WORD_W / 8);
    localparam int TAG_LSB   = `DCACHE_OFFSET_BITS + `DCACHE_INDEX_BITS;

    // ==================================================
    // request side
    // ==================================================
    assign addr_ok   = ~busy;               // only one access in flight.
    assign req_start = dreq_valid & addr_ok;

    // fields stay put until the next accepted request.
    always_ff @(posedge clk) begin
        if (req_start) begin
            req_tag    <= dreq_addr[`DCACHE_ADDR_W-1:TAG_LSB];
            req_index  <= dreq_addr[TAG_LSB-1:`DCACHE_OFFSET_BITS];
            req_word   <= dreq_addr[`DCACHE_OFFSET_BITS-1:BYTE_BITS];
            req_strobe <= dreq_strobe;
            req_wdata  <= dreq_wdata;
        end
    end

    // ==================================================
    // response side
    // ==================================================
    always_ff @(posedge clk) begin
        if (resetn) begin
            data_ok <= 1'b0;
        end else begin
            data_ok <= done;   // one-cycle pulse.
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            rdata <= done_rdata;
        end
    end

endmodule

//--- design/dcache_core.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_core (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  req_start,
    input  dcache_pkg::tag_t      req_tag,
    input  dcache_pkg::index_t    req_index,
    input  dcache_pkg::word_sel_t req_word,
    input  dcache_pkg::strobe_t   req_strobe,
    input  dcache_pkg::word_t     req_wdata,
    input  dcache_pkg::word_sel_t burst_word,
    input  logic                  fill_we,
    input  dcache_pkg::word_t     fill_data,
    input  logic                  burst_done,
    output logic                  busy,
    output logic                  done,
    output dcache_pkg::word_t     done_rdata,
    output logic                  burst_start,
    output logic                  burst_write,
    output dcache_pkg::addr_t     burst_addr,
    output dcache_pkg::word_t     rd_word
);
    localparam int SETS = 1 << `DCACHE_INDEX_BITS;

    dcache_pkg::meta_t        meta_mem [SETS][`DCACHE_WAYS];
    dcache_pkg::word_t        data_mem [SETS][`DCACHE_WAYS][`DCACHE_LINE_WORDS];
    dcache_pkg::cache_state_t state;
    dcache_pkg::way_t         way_q;   // victim way held across evict and fill.

    logic              hit;
    logic              found_inv;
    dcache_pkg::way_t  hit_way;
    dcache_pkg::way_t  inv_way;
    dcache_pkg::way_t  xor_way;
    dcache_pkg::way_t  sel_way;
    logic              victim_dirty;
    logic              wr_hit;
    dcache_pkg::word_t merged;
    dcache_pkg::addr_t evict_addr;
    dcache_pkg::addr_t fill_addr;

    // ==================================================
    // tag compare and way selection
    // ==================================================
    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        found_inv = 1'b0;
        inv_way   = '0;
        for (int w = 0; w < `DCACHE_WAYS; w++) begin
            if (!hit && meta_mem[req_index][w].valid && meta_mem[req_index][w].tag == req_tag) begin
                hit     = 1'b1;
                hit_way = dcache_pkg::way_t'(w);
            end
            if (!found_inv && !meta_mem[req_index][w].valid) begin
                found_inv = 1'b1;
                inv_way   = dcache_pkg::way_t'(w);
            end
        end
    end

    assign xor_way = req_tag[1:0] ^ req_tag[3:2] ^ req_tag[5:4] ^ req_tag[7:6];
    assign sel_way = hit ? hit_way : (found_inv ? inv_way : xor_way);

    assign victim_dirty = meta_mem[req_index][sel_way].valid
                          & meta_mem[req_index][sel_way].dirty;

    // byte merge of the write data into the stored word.
    always_comb begin
        merged = data_mem[req_index][sel_way][req_word];
        for (int b = 0; b < `DCACHE_WORD_W / 8; b++) begin
            if (req_strobe[b]) begin
                merged[b*8 +: 8] = req_wdata[b*8 +: 8];
            end
        end
    end

    // ==================================================
    // outputs
    // ==================================================
    assign busy       = (state != dcache_pkg::IDLE);
    assign done       = (state == dcache_pkg::LOOKUP) & hit;
    assign done_rdata = data_mem[req_index][sel_way][req_word];
    assign wr_hit     = done & (|req_strobe);

    assign evict_addr = {meta_mem[req_index][sel_way].tag, req_index,
                         {`DCACHE_OFFSET_BITS{1'b0}}};
    assign fill_addr  = {req_tag, req_index, {`DCACHE_OFFSET_BITS{1'b0}}};

    // fill starts right away after lookup, or once the write-back ends.
    assign burst_start = ((state == dcache_pkg::LOOKUP) & ~hit)
                         | ((state == dcache_pkg::EVICT) & burst_done);
    assign burst_write = (state == dcache_pkg::LOOKUP) & victim_dirty;
    assign burst_addr  = burst_write ? evict_addr : fill_addr;
    assign rd_word     = data_mem[req_index][way_q][burst_word];

    // ==================================================
    // controller
    // ==================================================
    always_ff @(posedge clk) begin
        if (resetn) begin
            state <= dcache_pkg::IDLE;
        end else begin
            case (state)
                dcache_pkg::IDLE: begin
                    if (req_start) state <= dcache_pkg::LOOKUP;
                end
                dcache_pkg::LOOKUP: begin
                    if (hit) begin
                        state <= dcache_pkg::RESPOND;
                    end else if (victim_dirty) begin
                        state <= dcache_pkg::EVICT;
                    end else begin
                        state <= dcache_pkg::FILL;
                    end
                end
                dcache_pkg::EVICT: begin
                    if (burst_done) state <= dcache_pkg::FILL;
                end
                dcache_pkg::FILL: begin
                    if (burst_done) state <= dcache_pkg::LOOKUP;   // now a hit.
                end
                default: state <= dcache_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == dcache_pkg::LOOKUP && !hit) begin
            way_q <= sel_way;
        end
    end

    // ==================================================
    // arrays
    // ==================================================
    always_ff @(posedge clk) begin
        if (resetn) begin
            for (int s = 0; s < SETS; s++) begin
                for (int w = 0; w < `DCACHE_WAYS; w++) begin
                    meta_mem[s][w] <= '0;
                end
            end
        end else if (wr_hit) begin
            meta_mem[req_index][sel_way].dirty <= 1'b1;
        end else if (state == dcache_pkg::FILL && burst_done) begin
            meta_mem[req_index][way_q] <= '{tag: req_tag, valid: 1'b1, dirty: 1'b0};
        end
    end

    always_ff @(posedge clk) begin
        if (fill_we && state == dcache_pkg::FILL) begin
            data_mem[req_index][way_q][burst_word] <= fill_data;
        end else if (wr_hit) begin
            data_mem[req_index][sel_way][req_word] <= merged;
        end
    end

endmodule

//--- design/line_burst.sv
`timescale 1ns/1ns

module line_burst (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  burst_start,
    input  logic                  burst_write,
    input  dcache_pkg::addr_t     burst_addr,
    input  dcache_pkg::word_t     rd_word,
    input  logic                  cresp_ready,
    input  logic                  cresp_last,
    input  dcache_pkg::word_t     cresp_rdata,
    output logic                  creq_valid,
    output logic                  creq_is_write,
    output dcache_pkg::addr_t     creq_addr,
    output dcache_pkg::word_t     creq_wdata,
    output dcache_pkg::word_sel_t burst_word,
    output logic                  fill_we,
    output dcache_pkg::word_t     fill_data,
    output logic                  burst_done
);
    logic                  active;
    logic                  done_q;
    dcache_pkg::word_sel_t beat;

    // ==================================================
    // beat counter
    // ==================================================
    always_ff @(posedge clk) begin
        if (resetn) begin
            active <= 1'b0;
            beat   <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            if (burst_start) begin
                active <= 1'b1;
                beat   <= '0;
            end else if (active && cresp_ready) begin
                beat <= beat + 1'b1;   // stalls while ready is low.
                if (cresp_last) begin
                    active <= 1'b0;
                    done_q <= 1'b1;
                end
            end
        end
    end

    // request held for the whole burst.
    always_ff @(posedge clk) begin
        if (burst_start) begin
            creq_is_write <= burst_write;
            creq_addr     <= burst_addr;
        end
    end

    assign creq_valid = active;
    assign creq_wdata = rd_word;   // victim word at the current beat.
    assign burst_word = beat;
    assign fill_we    = active & ~creq_is_write & cresp_ready;
    assign fill_data  = cresp_rdata;
    assign burst_done = done_q;

endmodule

//--- design/dcache_top.sv
`timescale 1ns/1ns

module dcache_top (
    input  logic                clk,
    input  logic                resetn,
    input  logic                dreq_valid,
    input  dcache_pkg::addr_t   dreq_addr,
    input  dcache_pkg::strobe_t dreq_strobe,
    input  dcache_pkg::word_t   dreq_wdata,
    output logic                addr_ok,
    output logic                data_ok,
    output dcache_pkg::word_t   rdata,
    output logic                creq_valid,
    output logic                creq_is_write,
    output dcache_pkg::addr_t   creq_addr,
    output dcache_pkg::word_t   creq_wdata,
    input  logic                cresp_ready,
    input  logic                cresp_last,
    input  dcache_pkg::word_t   cresp_rdata
);
    // ==================================================
    // internal links
    // ==================================================
    logic                  req_start;
    dcache_pkg::tag_t      req_tag;
    dcache_pkg::index_t    req_index;
    dcache_pkg::word_sel_t req_word;
    dcache_pkg::strobe_t   req_strobe;
    dcache_pkg::word_t     req_wdata;
    logic                  busy;
    logic                  done;
    dcache_pkg::word_t     done_rdata;
    logic                  burst_start;
    logic                  burst_write;
    dcache_pkg::addr_t     burst_addr;
    dcache_pkg::word_t     rd_word;
    dcache_pkg::word_sel_t burst_word;
    logic                  fill_we;
    dcache_pkg::word_t     fill_data;
    logic                  burst_done;

    dbus_front front_i (
        .clk        (clk),
        .resetn     (resetn),
        .dreq_valid (dreq_valid),
        .dreq_addr  (dreq_addr),
        .dreq_strobe(dreq_strobe),
        .dreq_wdata (dreq_wdata),
        .busy       (busy),
        .done       (done),
        .done_rdata (done_rdata),
        .addr_ok    (addr_ok),
        .data_ok    (data_ok),
        .rdata      (rdata),
        .req_start  (req_start),
        .req_tag    (req_tag),
        .req_index  (req_index),
        .req_word   (req_word),
        .req_strobe (req_strobe),
        .req_wdata  (req_wdata)
    );

    dcache_core core_i (
        .clk        (clk),
        .resetn     (resetn),
        .req_start  (req_start),
        .req_tag    (req_tag),
        .req_index  (req_index),
        .req_word   (req_word),
        .req_strobe (req_strobe),
        .req_wdata  (req_wdata),
        .burst_word (burst_word),
        .fill_we    (fill_we),
        .fill_data  (fill_data),
        .burst_done (burst_done),
        .busy       (busy),
        .done       (done),
        .done_rdata (done_rdata),
        .burst_start(burst_start),
        .burst_write(burst_write),
        .burst_addr (burst_addr),
        .rd_word    (rd_word)
    );

    line_burst burst_i (
        .clk          (clk),
        .resetn       (resetn),
        .burst_start  (burst_start),
        .burst_write  (burst_write),
        .burst_addr   (burst_addr),
        .rd_word      (rd_word),
        .cresp_ready  (cresp_ready),
        .cresp_last   (cresp_last),
        .cresp_rdata  (cresp_rdata),
        .creq_valid   (creq_valid),
        .creq_is_write(creq_is_write),
        .creq_addr    (creq_addr),
        .creq_wdata   (creq_wdata),
        .burst_word   (burst_word),
        .fill_we      (fill_we),
        .fill_data    (fill_data),
        .burst_done   (burst_done)
    );

endmodule

//--- tb/cbus_mem_model.sv
`timescale 1ns/1ns

module cbus_mem_model (
    input  logic              clk,
    input  logic              resetn,
    input  logic              creq_valid,
    input  logic              creq_is_write,
    input  dcache_pkg::addr_t creq_addr,
    input  dcache_pkg::word_t creq_wdata,
    output logic              cresp_ready,
    output logic              cresp_last,
    output dcache_pkg::word_t cresp_rdata,
    output logic              wb_seen,
    output dcache_pkg::addr_t wb_addr,
    output logic [127:0]      wb_line
);
    localparam int MEM_WORDS = 1024;   // 4 KB window.

    dcache_pkg::word_t mem [MEM_WORDS];
    logic [2:0]        beat;
    logic [9:0]        idx;
    int                gap;

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = ~(i * 4);   // inverse of the byte address.
        end
        cresp_ready = 1'b0;
        cresp_last  = 1'b0;
        cresp_rdata = '0;
        wb_seen     = 1'b0;
        wb_addr     = '0;
        wb_line     = '0;
        beat        = '0;
        gap         = 0;
    end

    // ==================================================
    // one beat per ready cycle, random gaps in between
    // ==================================================
    always @(negedge clk) begin
        wb_seen <= 1'b0;
        if (cresp_ready) begin
            beat = beat + 1'b1;   // previous beat was taken.
        end
        if (resetn || !creq_valid) begin
            beat = '0;
            gap  = $urandom_range(3, 0);
            cresp_ready <= 1'b0;
            cresp_last  <= 1'b0;
        end else if (gap > 0) begin
            gap = gap - 1;
            cresp_ready <= 1'b0;
            cresp_last  <= 1'b0;
        end else begin
            idx = {creq_addr[11:4], beat[1:0]};
            cresp_ready <= 1'b1;
            cresp_last  <= (beat == 3'd3);
            if (creq_is_write) begin
                mem[idx] = creq_wdata;
                wb_line[beat[1:0]*32 +: 32] <= creq_wdata;
            end else begin
                cresp_rdata <= mem[idx];
            end
            if (creq_is_write && beat == 3'd3) begin
                wb_seen <= 1'b1;   // whole line recorded.
                wb_addr <= creq_addr;
            end
            gap = $urandom_range(3, 0);
        end
    end

endmodule

//--- tb/dcache_tb.sv
`timescale 1ns/1ns
`include "dcache_params.svh"

module dcache_tb;
    localparam int MEM_WORDS   = 1024;
    localparam int CYCLE_LIMIT = 4000;   // about 80 accesses at 40 cycles, with margin.

    logic                clk;
    logic                resetn;
    logic                dreq_valid;
    dcache_pkg::addr_t   dreq_addr;
    dcache_pkg::strobe_t dreq_strobe;
    dcache_pkg::word_t   dreq_wdata;
    logic                addr_ok;
    logic                data_ok;
    dcache_pkg::word_t   rdata;
    logic                creq_valid;
    logic                creq_is_write;
    dcache_pkg::addr_t   creq_addr;
    dcache_pkg::word_t   creq_wdata;
    logic                cresp_ready;
    logic                cresp_last;
    dcache_pkg::word_t   cresp_rdata;
    logic                wb_seen;
    dcache_pkg::addr_t   wb_addr;
    logic [127:0]        wb_line;

    dcache_pkg::word_t shadow [MEM_WORDS];
    string             test_name = "reset";
    int                cycles    = 0;
    int                wb_count  = 0;
    int                latency;
    int                creq_seen;
    int                seed_val;

    dcache_top dut_i (
        .clk          (clk),
        .resetn       (resetn),
        .dreq_valid   (dreq_valid),
        .dreq_addr    (dreq_addr),
        .dreq_strobe  (dreq_strobe),
        .dreq_wdata   (dreq_wdata),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rdata        (rdata),
        .creq_valid   (creq_valid),
        .creq_is_write(creq_is_write),
        .creq_addr    (creq_addr),
        .creq_wdata   (creq_wdata),
        .cresp_ready  (cresp_ready),
        .cresp_last   (cresp_last),
        .cresp_rdata  (cresp_rdata)
    );

    cbus_mem_model mem_i (
        .clk          (clk),
        .resetn       (resetn),
        .creq_valid   (creq_valid),
        .creq_is_write(creq_is_write),
        .creq_addr    (creq_addr),
        .creq_wdata   (creq_wdata),
        .cresp_ready  (cresp_ready),
        .cresp_last   (cresp_last),
        .cresp_rdata  (cresp_rdata),
        .wb_seen      (wb_seen),
        .wb_addr      (wb_addr),
        .wb_line      (wb_line)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // ==================================================
    // checks, timeout and write-back monitor
    // ==================================================
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles without finishing", cycles);
            $display("TEST FAILED");
            $fatal(1, "timeout");
        end
    end

    // an evicted line must match the shadow copy.
    always @(posedge clk) begin
        if (wb_seen) begin
            wb_count++;
            for (int i = 0; i < `DCACHE_LINE_WORDS; i++) begin
                check_value(test_name, shadow[wb_addr[11:2] + i], wb_line[i*32 +: 32]);
            end
        end
    end

    // ==================================================
    // processor bus helpers
    // ==================================================
    task automatic apply_shadow(input dcache_pkg::addr_t addr, input dcache_pkg::strobe_t strobe,
                                input dcache_pkg::word_t wdata);
        for (int b = 0; b < 4; b++) begin
            if (strobe[b]) shadow[addr[11:2]][b*8 +: 8] = wdata[b*8 +: 8];
        end
    endtask

    task automatic access(input dcache_pkg::addr_t addr, input dcache_pkg::strobe_t strobe,
                          input dcache_pkg::word_t wdata, output dcache_pkg::word_t result);
        @(negedge clk);
        while (!addr_ok) @(negedge clk);
        dreq_valid  = 1'b1;
        dreq_addr   = addr;
        dreq_strobe = strobe;
        dreq_wdata  = wdata;
        @(negedge clk);   // taken on the edge in between.
        dreq_valid = 1'b0;
        latency    = 1;
        creq_seen  = creq_valid;
        while (!data_ok) begin
            @(negedge clk);
            latency++;
            if (creq_valid) creq_seen = 1;
        end
        result = rdata;
        apply_shadow(addr, strobe, wdata);
    endtask

    task automatic write_word(input dcache_pkg::addr_t addr, input dcache_pkg::strobe_t strobe,
                              input dcache_pkg::word_t wdata);
        dcache_pkg::word_t unused;
        access(addr, strobe, wdata, unused);
    endtask

    task automatic read_check(input dcache_pkg::addr_t addr);
        dcache_pkg::word_t got;
        access(addr, '0, '0, got);
        check_value(test_name, shadow[addr[11:2]], got);
    endtask

    // five lines in set 2, one in each other set.
    function automatic dcache_pkg::addr_t line_base(input int n);
        int set_num;
        set_num = (n < 5) ? 2 : ((n == 5) ? 0 : ((n == 6) ? 1 : 3));
        return ((20 + n) << 6) | (set_num << 4);
    endfunction

    // ==================================================
    // tests
    // ==================================================
    task automatic cold_read();
        int start_wb;
        test_name = "cold_read";
        start_wb  = wb_count;
        read_check(32'h000);
        read_check(32'h014);
        read_check(32'h028);
        read_check(32'h03C);
        read_check(32'h004);
        check_value(test_name, start_wb, wb_count);   // nothing dirty yet.
    endtask

    task automatic strobe_write();
        test_name = "strobe_write";
        write_word(32'h000, 4'b0001, $urandom);
        write_word(32'h018, 4'b0110, $urandom);
        write_word(32'h024, 4'b1000, $urandom);
        write_word(32'h03C, 4'b1111, $urandom);
        write_word(32'h108, 4'b0101, $urandom);   // write miss.
        write_word(32'h000, 4'b1010, $urandom);
        read_check(32'h000);
        read_check(32'h018);
        read_check(32'h024);
        read_check(32'h03C);
        read_check(32'h108);
        read_check(32'h10C);
    endtask

    task automatic hit_timing();
        dcache_pkg::word_t got;
        test_name = "hit_timing";
        read_check(32'h014);
        access(32'h014, '0, '0, got);
        check_value(test_name, 2, latency);
        check_value(test_name, 0, creq_seen);
        check_value(test_name, shadow[32'h014 >> 2], got);
        @(negedge clk);
        check_value(test_name, 0, data_ok);   // single-cycle pulse.
    endtask

    task automatic dirty_evict();
        int start_wb;
        test_name = "dirty_evict";
        start_wb  = wb_count;
        for (int i = 0; i < 5; i++) begin
            write_word(32'h214 + i * 64, 4'b1111, $urandom);
        end
        for (int i = 0; i < 5; i++) begin
            read_check(32'h214 + i * 64);
        end
        check_value(test_name, 1, wb_count > start_wb);
    endtask

    task automatic mixed_random();
        dcache_pkg::addr_t   addr;
        dcache_pkg::strobe_t strobe;
        test_name = "mixed_random";
        for (int i = 0; i < 40; i++) begin
            addr = line_base($urandom_range(7, 0)) | ($urandom_range(3, 0) << 2);
            if ($urandom_range(1, 0) == 1) begin
                strobe = $urandom_range(15, 1);
                write_word(addr, strobe, $urandom);
            end else begin
                read_check(addr);
            end
        end
        for (int n = 0; n < 8; n++) begin
            read_check(line_base(n));
        end
    endtask

    initial begin
        seed_val    = $urandom(27200);
        resetn      = 1'b1;
        dreq_valid  = 1'b0;
        dreq_addr   = '0;
        dreq_strobe = '0;
        dreq_wdata  = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            shadow[i] = ~(i * 4);
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        resetn = 1'b0;
        check_value(test_name, 1, addr_ok);
        check_value(test_name, 0, data_ok);
        check_value(test_name, 0, creq_valid);
        cold_read();
        strobe_write();
        hit_timing();
        dirty_evict();
        mixed_random();
        $display("TEST PASSED");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
design/dcache_pkg.sv
design/dbus_front.sv
design/dcache_core.sv
design/line_burst.sv
design/dcache_top.sv
tb/cbus_mem_model.sv
tb/dcache_tb.sv
